/* hdl/cpuPkg.sv */
// Shared types for the single-cycle core; opcode and condition numbering is fixed by the ISA
`default_nettype none

package cpuPkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  localparam int DataWidth = 16;  // Data word
  localparam int AddrWidth = 16;  // Byte address
  localparam int RegCount  = 16;  // Architectural registers
  localparam int ImemDepth = 256; // Program words
  localparam int DmemDepth = 256; // Data words

  // Opcode in instr[15:12]
  typedef enum logic [3:0] {
    OpAdd = 4'h0, OpSub = 4'h1, OpXor = 4'h2, OpAnd = 4'h3,
    OpSll = 4'h4, OpSra = 4'h5, OpRor = 4'h6, OpOr  = 4'h7,
    OpLw  = 4'h8, OpSw  = 4'h9, OpLlb = 4'hA, OpLhb = 4'hB,
    OpB   = 4'hC, OpBr  = 4'hD, OpPcs = 4'hE, OpHlt = 4'hF
  } opcodeE;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    CondNe = 3'd0, // Z=0
    CondEq = 3'd1, // Z=1
    CondGt = 3'd2, // Z=0 and N=0
    CondLt = 3'd3, // N=1
    CondGe = 3'd4, // Z=1, or Z=0 and N=0
    CondLe = 3'd5, // N=1 or Z=1
    CondOv = 3'd6, // V=1
    CondAl = 3'd7  // Unconditional
  } condE;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////
  typedef struct packed {
    logic       aluSrc;    // Second operand from immediate
    logic       memToReg;  // Write back memory data
    logic       regWrite;  // Register write
    logic       regSrc;    // Source 1 comes from the destination field
    logic       memEnable; // Memory access, picks the offset extension
    logic       memWrite;  // Store
    logic       branch;    // B or BR
    logic       branchReg; // BR target from register
    logic       halt;
    logic       pcs;       // Write back PC plus 2
    logic [3:0] aluOp;     // Same codes as the opcodes
    logic       zEn;       // Z update
    logic       nvEn;      // N and V update
  } ctrlT;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

  typedef struct packed {
    logic                 valid; // One cycle per register write
    logic [3:0]           dst;
    logic [DataWidth-1:0] data;
  } wbT;

  typedef struct packed {
    logic                 valid;
    logic [7:0]           addr;  // Word index
    logic [DataWidth-1:0] data;
  } imemLoadT;

endpackage

`default_nettype wire

/* hdl/instMemory.sv */
// Program store, loaded only through the load port while the core sits in reset; no init file
`timescale 1ns/10ps
`default_nettype none

module instMemory (
  input  wire logic                                 clk,
  input  wire cpuPkg::imemLoadT                     load,
  input  wire logic [$clog2(cpuPkg::ImemDepth)-1:0] addr,
  output logic      [cpuPkg::DataWidth-1:0]         instr
);
  import cpuPkg::*;

  logic [DataWidth-1:0] mem [ImemDepth]; // Word array, contents undefined until loaded

  always_ff @(posedge clk) begin
    if (load.valid) begin
      mem[load.addr] <= load.data; // Program load
    end
  end

  assign instr = mem[addr]; // Fetch is combinational

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
// Pure decode table; no state, every opcode has a defined control set
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
  input  wire cpuPkg::opcodeE opcode,
  output cpuPkg::ctrlT        ctrl
);
  import cpuPkg::*;

  always_comb begin
    ctrl = '0; // Nothing enabled by default
    unique case (opcode)
      OpAdd, OpSub, OpXor, OpAnd, OpOr: begin // Register-register ALU ops
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = (opcode == OpAdd) || (opcode == OpSub); // Only add/sub touch N and V
      end
      OpSll, OpSra, OpRor: begin // Shift amount is the 4-bit immediate
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
      end
      OpLw: begin
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = OpAdd; // Base plus offset
      end
      OpSw: begin
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluOp     = OpAdd;
      end
      OpLlb, OpLhb: begin // Read-modify-write of rd with the byte immediate
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode; // Byte-merge codes
      end
      OpB: ctrl.branch = 1'b1;
      OpBr: begin
        ctrl.branch    = 1'b1;
        ctrl.branchReg = 1'b1;
      end
      OpPcs: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcs      = 1'b1;
      end
      OpHlt: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
// Flop-based register file, register 0 reads zero; reads see the array, so a write shows up next cycle
`timescale 1ns/10ps
`default_nettype none

module registerFile (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic [3:0]                   rdAddr1,
  input  wire logic [3:0]                   rdAddr2,
  input  wire logic                         wrEn,
  input  wire logic [3:0]                   wrAddr,
  input  wire logic [cpuPkg::DataWidth-1:0] wrData,
  output logic      [cpuPkg::DataWidth-1:0] rdData1,
  output logic      [cpuPkg::DataWidth-1:0] rdData2
);
  import cpuPkg::*;

  logic [DataWidth-1:0] regs [RegCount];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != 4'd0)) begin // R0 stays zero
      regs[wrAddr] <= wrData;
    end
  end

  // Written value lands at the edge, so the next instruction reads it
  assign rdData1 = regs[rdAddr1];
  assign rdData2 = regs[rdAddr2];

endmodule

`default_nettype wire

/* hdl/alu.sv */
// Combinational ALU; add/sub wrap, V is signed overflow of add/sub only, shifts use b[3:0]
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire logic [cpuPkg::DataWidth-1:0] a,
  input  wire logic [cpuPkg::DataWidth-1:0] b,
  input  wire logic [3:0]                   op,
  output logic      [cpuPkg::DataWidth-1:0] result,
  output cpuPkg::flagsT                     flags
);
  import cpuPkg::*;

  logic [DataWidth-1:0]   sum;     // a + b, wrapped
  logic [DataWidth-1:0]   diff;    // a - b, wrapped
  logic [2*DataWidth-1:0] rotWide; // Doubled word for the rotate
  logic [3:0]             shamt;
  logic                   addOv;
  logic                   subOv;

  assign shamt   = b[3:0];
  assign sum     = a + b;
  assign diff    = a - b;
  assign rotWide = {a, a} >> shamt;

  // Same-sign inputs with a flipped result sign
  assign addOv = (a[DataWidth-1] == b[DataWidth-1]) && (sum[DataWidth-1] != a[DataWidth-1]);
  // Opposite-sign inputs, result sign differs from a
  assign subOv = (a[DataWidth-1] != b[DataWidth-1]) && (diff[DataWidth-1] != a[DataWidth-1]);

  always_comb begin
    unique case (opcodeE'(op))
      OpAdd:   result = sum;
      OpSub:   result = diff;
      OpXor:   result = a ^ b;
      OpAnd:   result = a & b;
      OpOr:    result = a | b;
      OpSll:   result = a << shamt;
      OpSra:   result = $signed(a) >>> shamt; // Keeps the sign
      OpRor:   result = rotWide[DataWidth-1:0];
      OpLlb:   result = {a[DataWidth-1:8], b[7:0]}; // Low byte replaced
      OpLhb:   result = {b[7:0], a[7:0]};           // High byte replaced
      default: result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Candidate flags, latched by branchUnit
  ////////////////////////////////////////
  always_comb begin
    flags.z = (result == '0);
    flags.n = result[DataWidth-1];
    unique case (opcodeE'(op))
      OpAdd:   flags.v = addOv;
      OpSub:   flags.v = subOv;
      default: flags.v = 1'b0; // Never latched outside add/sub
    endcase
  end

endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
// Flag register plus next-PC select; branches test flags stored by earlier instructions only
`timescale 1ns/10ps
`default_nettype none

module branchUnit (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire cpuPkg::flagsT                aluFlags,
  input  wire logic                         zEn,
  input  wire logic                         nvEn,
  input  wire logic                         branch,
  input  wire logic                         branchReg,
  input  wire logic                         halt,
  input  wire cpuPkg::condE                 cond,
  input  wire logic [8:0]                   offset,
  input  wire logic [cpuPkg::AddrWidth-1:0] target,
  input  wire logic [cpuPkg::AddrWidth-1:0] pc,
  output logic      [cpuPkg::AddrWidth-1:0] nextPc,
  output logic      [cpuPkg::AddrWidth-1:0] pcPlus2
);
  import cpuPkg::*;

  flagsT                flagReg;  // Stored Z, N, V
  logic                 condMet;
  logic                 taken;
  logic [AddrWidth-1:0] relTarget; // PC + 2 + 2*offset

  always_ff @(posedge clk) begin
    if (rst) begin
      flagReg <= '0;
    end else begin
      if (zEn)  flagReg.z <= aluFlags.z;
      if (nvEn) begin
        flagReg.n <= aluFlags.n;
        flagReg.v <= aluFlags.v;
      end
    end
  end

  always_comb begin
    unique case (cond)
      CondNe:  condMet = !flagReg.z;
      CondEq:  condMet = flagReg.z;
      CondGt:  condMet = !flagReg.z && !flagReg.n;
      CondLt:  condMet = flagReg.n;
      CondGe:  condMet = flagReg.z || !flagReg.n;
      CondLe:  condMet = flagReg.n || flagReg.z;
      CondOv:  condMet = flagReg.v;
      default: condMet = 1'b1; // Always
    endcase
  end

  assign taken     = branch && condMet;
  assign pcPlus2   = pc + AddrWidth'(2);
  assign relTarget = pcPlus2 + {{(AddrWidth-10){offset[8]}}, offset, 1'b0}; // Word offset

  always_comb begin
    if (halt)                    nextPc = pc;        // Parked on HLT
    else if (taken && branchReg) nextPc = target;    // BR
    else if (taken)              nextPc = relTarget; // B
    else                         nextPc = pcPlus2;
  end

endmodule

`default_nettype wire

/* hdl/dataMemory.sv */
// Word-addressed data RAM using addr[8:1]; no reset, contents persist across core resets
`timescale 1ns/10ps
`default_nettype none

module dataMemory (
  input  wire logic                         clk,
  input  wire logic [cpuPkg::AddrWidth-1:0] addr,
  input  wire logic [cpuPkg::DataWidth-1:0] wrData,
  input  wire logic                         wrEn,
  output logic      [cpuPkg::DataWidth-1:0] rdData
);
  import cpuPkg::*;

  localparam int IdxWidth = $clog2(DmemDepth);

  logic [DataWidth-1:0] mem [DmemDepth];
  logic [IdxWidth-1:0]  wordIdx; // Byte address to word index

  assign wordIdx = addr[IdxWidth:1];

  always_ff @(posedge clk) begin
    if (wrEn) mem[wordIdx] <= wrData; // Store lands at the edge
  end

  assign rdData = mem[wordIdx]; // Load is combinational

endmodule

`default_nettype wire

/* hdl/cpuCore.sv */
// Single-cycle core top; program must be loaded through imemLoad while rst is high
`timescale 1ns/10ps
`default_nettype none

module cpuCore (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire cpuPkg::imemLoadT             imemLoad,
  output logic      [cpuPkg::AddrWidth-1:0] pc,
  output logic                              halt,
  output cpuPkg::wbT                        wb
);
  import cpuPkg::*;

  localparam int ImemIdxWidth = $clog2(ImemDepth);

  imemLoadT             loadGated;   // Load strobe passed only during reset
  logic [DataWidth-1:0] instr;
  ctrlT                 ctrl;
  opcodeE               opcode;
  condE                 cond;
  logic [3:0]           dst, src1, src2;
  logic [3:0]           rdAddr1, rdAddr2;
  logic [DataWidth-1:0] rdData1, rdData2;
  logic [DataWidth-1:0] shiftImm, memOffset, byteImm, aluImm, aluB;
  logic [DataWidth-1:0] aluResult, memData, wrData;
  flagsT                aluFlags;
  logic [AddrWidth-1:0] nextPc, pcPlus2;

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) pc <= '0;
    else     pc <= nextPc;
  end

  always_comb begin
    loadGated       = imemLoad;
    loadGated.valid = imemLoad.valid && rst; // No program writes while running
  end

  instMemory uInstMemory (
    .clk   (clk),
    .load  (loadGated),
    .addr  (pc[ImemIdxWidth:1]), // Word fetch
    .instr (instr)
  );

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  assign opcode = opcodeE'(instr[15:12]);
  assign dst    = instr[11:8];
  assign src1   = instr[7:4];
  assign src2   = instr[3:0];
  assign cond   = condE'(instr[11:9]); // B and BR

  controlUnit uControlUnit (.opcode(opcode), .ctrl(ctrl));

  assign rdAddr1 = ctrl.regSrc   ? dst : src1; // LLB/LHB merge into rd
  assign rdAddr2 = ctrl.memWrite ? dst : src2; // SW stores rd

  registerFile uRegisterFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (rdAddr1),
    .rdAddr2 (rdAddr2),
    .wrEn    (ctrl.regWrite),
    .wrAddr  (dst),
    .wrData  (wrData),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  assign shiftImm  = {{(DataWidth-4){1'b0}}, src2};                // Shift amount
  assign memOffset = {{(DataWidth-5){src2[3]}}, src2, 1'b0};       // Signed words to bytes
  assign byteImm   = {{(DataWidth-8){1'b0}}, instr[7:0]};          // LLB/LHB byte
  assign aluImm    = ctrl.regSrc ? byteImm : (ctrl.memEnable ? memOffset : shiftImm);
  assign aluB      = ctrl.aluSrc ? aluImm : rdData2;

  alu uAlu (
    .a      (rdData1),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .flags  (aluFlags)
  );

  branchUnit uBranchUnit (
    .clk       (clk),
    .rst       (rst),
    .aluFlags  (aluFlags),
    .zEn       (ctrl.zEn),
    .nvEn      (ctrl.nvEn),
    .branch    (ctrl.branch),
    .branchReg (ctrl.branchReg),
    .halt      (ctrl.halt),
    .cond      (cond),
    .offset    (instr[8:0]),
    .target    (rdData1),    // BR register
    .pc        (pc),
    .nextPc    (nextPc),
    .pcPlus2   (pcPlus2)
  );

  ////////////////////////////////////////
  // Memory and write-back
  ////////////////////////////////////////
  dataMemory uDataMemory (
    .clk    (clk),
    .addr   (aluResult),
    .wrData (rdData2),
    .wrEn   (ctrl.memWrite && !rst), // Held off while the program loads
    .rdData (memData)
  );

  assign wrData = ctrl.memToReg ? memData : (ctrl.pcs ? pcPlus2 : aluResult);

  assign halt     = ctrl.halt; // Rises in the HLT fetch cycle
  assign wb.valid = ctrl.regWrite && (dst != 4'd0) && !rst; // No report for R0 or in reset
  assign wb.dst   = dst;
  assign wb.data  = wrData;

endmodule

`default_nettype wire

/* dv/clockGen.sv */
// Testbench clock and reset; rst is high for the first cycles and whenever hold is high
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 4
) (
  input  wire logic hold, // Extra reset time asked for by the testbench
  output logic      clk,
  output logic      rst
);
  logic initRst; // Power-on reset

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  initial begin
    initRst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1 initRst = 1'b0; // Released just after the edge
  end

  assign rst = initRst || hold;

endmodule

`default_nettype wire

/* dv/cpuTb.sv */
// Each table program runs after its own reset; the core is seen only through wb, pc and halt
`timescale 1ns/10ps
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  localparam int ClkPeriod      = 20;
  localparam int ResetCycles    = 4;
  localparam int NumProgs       = 5;
  localparam int NumWords       = 106; // Sum of progLen
  localparam int NumEvents      = 49;  // Sum of evCount
  localparam int WatchdogCycles = NumWords * 4 + ResetCycles * (NumProgs + 1);

  logic                 clk;
  logic                 rst;
  logic                 hold;     // Core held in reset while a program loads
  imemLoadT             imemLoad;
  logic [AddrWidth-1:0] pc;
  logic                 halt;
  wbT                   wb;
  int                   checks;
  int                   errors;

  ////////////////////////////////////////
  // Program table
  ////////////////////////////////////////
  string       progName [NumProgs] = '{"alu", "memory", "flags", "brPcs", "reset"};
  int          progLen  [NumProgs] = '{15, 10, 65, 11, 5};
  int          evCount  [NumProgs] = '{13, 7, 20, 7, 2};
  logic [15:0] haltPc   [NumProgs] = '{16'h001C, 16'h0012, 16'h0080, 16'h0014, 16'h0006};

  // Instruction words of all programs back to back
  logic [15:0] progWords [NumWords] = '{
    // LLB/LHB build operands, eight ALU ops, a write to r0, an OR reading r0
    16'hA134, 16'hB112, 16'hA20F, 16'hB2F0, 16'h0312, 16'h1412, 16'h2512, 16'h3612,
    16'h7712, 16'h4814, 16'h5924, 16'h6A14, 16'h0012, 16'h7B01, 16'hF000,
    // SW then LW around base 0x40 with offsets +3 and -2 words
    16'hA140, 16'hA2AB, 16'hB2CD, 16'hA377, 16'h9213, 16'h931E, 16'h8413, 16'h851E,
    16'h0645, 16'hF000,
    // ADD overflow, then B over an LLB r15 marker for every condition
    16'hA1FF, 16'hB17F, 16'hA201, 16'h0312,
    16'hC001, 16'hAF10, 16'hC201, 16'hAF11, 16'hC401, 16'hAF12, 16'hC601, 16'hAF13,
    16'hC801, 16'hAF14, 16'hCA01, 16'hAF15, 16'hCC01, 16'hAF16, 16'hCE01, 16'hAF17,
    16'h2620, 16'hC401, 16'hAF22, 16'hCC01, 16'hAF26, 16'hC601, 16'hAF23, // XOR keeps N, V
    16'h1411, // Zero SUB
    16'hC001, 16'hAF30, 16'hC201, 16'hAF31, 16'hC401, 16'hAF32, 16'hC601, 16'hAF33,
    16'hC801, 16'hAF34, 16'hCA01, 16'hAF35, 16'hCC01, 16'hAF36, 16'hCE01, 16'hAF37,
    16'h1502, // Negative SUB
    16'hC001, 16'hAF40, 16'hC201, 16'hAF41, 16'hC401, 16'hAF42, 16'hC601, 16'hAF43,
    16'hC801, 16'hAF44, 16'hCA01, 16'hAF45, 16'hCC01, 16'hAF46, 16'hCE01, 16'hAF47,
    16'h0722, 16'hC401, 16'hAF52, 16'hF000, // Positive ADD makes GT taken
    // Counted BR loop back to a PCS address, then BR always over two words
    16'hA202, 16'hA301, 16'hE100, 16'h1223, 16'hD010, 16'hE400, 16'hA514, 16'hDE50,
    16'hAF99, 16'hAF98, 16'hF000,
    // Flags and registers read zero after reset and the word after HLT never runs
    16'hC201, 16'hA666, 16'h7145, 16'hF000, 16'hA355
  };

  // Expected write-backs as {dst, data} in program order
  logic [19:0] expEvents [NumEvents] = '{
    20'h1_0034, 20'h1_1234, 20'h2_000F, 20'h2_F00F, 20'h3_0243, 20'h4_2225, 20'h5_E23B,
    20'h6_1004, 20'h7_F23F, 20'h8_2340, 20'h9_FF00, 20'hA_4123, 20'hB_1234,
    20'h1_0040, 20'h2_00AB, 20'h2_CDAB, 20'h3_0077, 20'h4_CDAB, 20'h5_0077, 20'h6_CE22,
    20'h1_00FF, 20'h1_7FFF, 20'h2_0001, 20'h3_8000, 20'hF_0011, 20'hF_0012, 20'hF_0014,
    20'h6_0001, 20'hF_0022, 20'h4_0000, 20'hF_0030, 20'hF_0032, 20'hF_0033, 20'hF_0036,
    20'h5_FFFF, 20'hF_0041, 20'hF_0042, 20'hF_0044, 20'hF_0046, 20'h7_0002,
    20'h2_0002, 20'h3_0001, 20'h1_0006, 20'h2_0001, 20'h2_0000, 20'h4_000C, 20'h5_0014,
    20'h6_0066, 20'h1_0000
  };

  clockGen #(
    .PeriodNs    (ClkPeriod),
    .ResetCycles (ResetCycles)
  ) uClockGen (
    .hold (hold),
    .clk  (clk),
    .rst  (rst)
  );

  cpuCore UUT (
    .clk      (clk),
    .rst      (rst),
    .imemLoad (imemLoad),
    .pc       (pc),
    .halt     (halt),
    .wb       (wb)
  );

  // Compares one observed value with its expected value
  task automatic checkValue(input string sigName, input logic [15:0] got,
                            input logic [15:0] expected);
    checks++;
    if (got !== expected) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", sigName, got, expected);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Load, reset and run one program
  ////////////////////////////////////////
  task automatic runProgram(input int p, input int wordBase, input int evBase);
    int          evIdx;
    int          errBefore;
    logic [19:0] expEv;
    errBefore = errors;
    @(posedge clk);
    #1;
    hold = 1'b1;
    for (int i = 0; i < progLen[p]; i++) begin
      imemLoad = '{valid: 1'b1, addr: 8'(i), data: progWords[wordBase + i]};
      @(posedge clk);
      #1;
    end
    imemLoad = '0;
    repeat (ResetCycles) begin // Clears registers, flags and pc
      @(posedge clk);
      #1;
      if (wb.valid !== 1'b0) begin
        $display("%s: write-back reported while the core was in reset", progName[p]);
        errors++;
      end
    end
    hold  = 1'b0; // First instruction executes in this cycle
    evIdx = 0;
    @(negedge clk);
    while (halt !== 1'b1) begin
      if (wb.valid === 1'b1) begin
        if (evIdx < evCount[p]) begin
          expEv = expEvents[evBase + evIdx];
          checkValue("wb.dst", 16'(wb.dst), 16'(expEv[19:16]));
          checkValue("wb.data", wb.data, expEv[15:0]);
        end else begin
          $display("%s: extra write-back to r%0d at pc 0x%h", progName[p], wb.dst, pc);
          errors++;
        end
        evIdx++;
      end
      @(negedge clk);
    end
    checkValue("pc", pc, haltPc[p]); // Parked on the HLT word
    repeat (2) begin
      @(negedge clk);
      if (halt !== 1'b1 || wb.valid !== 1'b0) begin
        $display("%s: core did not stay halted without write-backs", progName[p]);
        errors++;
      end
      checkValue("pc", pc, haltPc[p]);
    end
    if (evIdx < evCount[p]) begin
      $display("%s: %0d expected write-backs never appeared", progName[p], evCount[p] - evIdx);
      errors++;
    end
    $display("test %s: %s (%0d errors)", progName[p],
             (errors == errBefore) ? "ok" : "fail", errors - errBefore);
  endtask

  initial begin
    int wordBase;
    int evBase;
    hold     = 1'b1;
    imemLoad = '0;
    checks   = 0;
    errors   = 0;
    wordBase = 0;
    evBase   = 0;
    for (int p = 0; p < NumProgs; p++) begin
      runProgram(p, wordBase, evBase);
      wordBase += progLen[p];
      evBase   += evCount[p];
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NumProgs, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog allows four cycles per program word plus the resets
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired before all programs halted");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/cpuPkg.sv
hdl/instMemory.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/dataMemory.sv
hdl/cpuCore.sv
dv/clockGen.sv
dv/cpuTb.sv

/* Makefile */
# Verilator build and run for the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
